// ==== rv_isa_pkg.sv ====
// RV32I word-only subset; both memories hold 64 words and every address wraps on the word index
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int MEM_IDX_W  = $clog2(IMEM_DEPTH);  // Same index width for both memories
    localparam int PC_STEP    = 4;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(NUM_REGS)-1:0]  reg_addr_t;
    typedef logic [MEM_IDX_W-1:0]         mem_index_t;
    typedef logic [6:0]                   opcode_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ     // Branch compare only
    } alu_op_t;

endpackage

// ==== core_ctrl_pkg.sv ====
// Control encodings of the multi-cycle core; zero in every field of ctrl_t means no action
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_REG,
        ALU_IMM,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        LUI,
        AUIPC,
        ILLEGAL
    } instr_class_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITE_BACK,
        NEXT_PC
    } seq_state_t;

    typedef enum logic [1:0] {
        HOLD,        // Must stay the zero code
        STEP,
        OFFSET,
        REG_TARGET
    } pc_sel_t;

    typedef enum logic [2:0] {
        LINK,
        IMM_U,
        PC_IMM_U,
        ALU,
        MEM
    } wb_sel_t;

    typedef struct packed {
        instr_class_t          instr_class;
        rv_isa_pkg::alu_op_t   alu_op;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     imm;     // Already sign extended
        rv_isa_pkg::word_t     pc;      // PC of the instruction in the IR
        logic [2:0]            funct3;
    } decoded_t;

    typedef struct packed {
        logic    ir_load;
        pc_sel_t pc_sel;
        logic    use_imm;
        logic    result_load;
        logic    mem_we;
        logic    mem_re;
        logic    rf_we;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
    } wb_event_t;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t addr;    // Byte address as computed
        rv_isa_pkg::word_t data;
    } store_event_t;

endpackage

// ==== alu.sv ====
// Combinational ALU; shifts take b[4:0], compares return 0 or 1 in bit 0
`timescale 1ns/10ps

module alu (
    input  rv_isa_pkg::alu_op_t op,
    input  rv_isa_pkg::word_t   a,
    input  rv_isa_pkg::word_t   b,
    output rv_isa_pkg::word_t   result
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_EQ:   result = {{(XLEN-1){1'b0}}, a == b};
            default:  result = '0;
        endcase
    end

endmodule

// ==== reg_file.sv ====
// 32 x 32 register file; x0 reads zero because writes to it are dropped and reset clears it
`timescale 1ns/10ps

module reg_file (
    input  logic                     clock,
    input  logic                     data_mem_rst,
    input  rv_isa_pkg::reg_addr_t    rs1_addr,
    input  rv_isa_pkg::reg_addr_t    rs2_addr,
    input  core_ctrl_pkg::wb_event_t write,
    output rv_isa_pkg::word_t        rs1_data,
    output rv_isa_pkg::word_t        rs2_data
);
    import rv_isa_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clock) begin
        if (data_mem_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid && (write.rd != '0)) begin
            regs[write.rd] <= write.data;
        end
    end

    // Combinational reads
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== instr_fetch.sv ====
// PC, 64-word instruction memory and decoder; the IR changes only on ir_load, PC only in NEXT_PC
`timescale 1ns/10ps

module instr_fetch (
    input  logic                    clock,
    input  logic                    data_mem_rst,
    input  logic                    imem_we,
    input  rv_isa_pkg::mem_index_t  imem_addr,
    input  rv_isa_pkg::word_t       imem_data,
    input  core_ctrl_pkg::ctrl_t    ctrl,
    input  rv_isa_pkg::word_t       jump_target,
    output core_ctrl_pkg::decoded_t decoded,
    output rv_isa_pkg::word_t       pc
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t      imem [IMEM_DEPTH];
    word_t      pc_q;
    word_t      ir_q;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;      // funct7 bit 5 selects SUB and SRA

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub_ok, input logic a);
        case (f3)
            3'b000:  return (sub_ok && a) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return a ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;  // Loader port, open at all times
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.ir_load) begin
            ir_q <= imem[mem_index_t'(pc_q >> 2)];
        end
    end

    always_ff @(posedge clock) begin
        if (data_mem_rst) begin
            pc_q <= '0;
        end else begin
            case (ctrl.pc_sel)
                STEP:       pc_q <= pc_q + word_t'(PC_STEP);
                OFFSET:     pc_q <= pc_q + decoded.imm;  // Branch and JAL
                REG_TARGET: pc_q <= jump_target;
                default:    pc_q <= pc_q;
            endcase
        end
    end

    assign opcode = ir_q[6:0];
    assign funct3 = ir_q[14:12];
    assign alt    = ir_q[30];

    always_comb begin
        decoded.rs1         = ir_q[19:15];
        decoded.rs2         = ir_q[24:20];
        decoded.rd          = ir_q[11:7];
        decoded.funct3      = funct3;
        decoded.pc          = pc_q;
        decoded.instr_class = ILLEGAL;
        decoded.alu_op      = ALU_ADD;
        decoded.imm         = {{20{ir_q[31]}}, ir_q[31:20]};  // I-type by default
        case (opcode)
            OPC_OP: begin
                decoded.instr_class = ALU_REG;
                decoded.alu_op      = arith_op(funct3, 1'b1, alt);
            end
            OPC_OP_IMM: begin
                decoded.instr_class = ALU_IMM;
                decoded.alu_op      = arith_op(funct3, 1'b0, alt);
            end
            OPC_LOAD:   decoded.instr_class = LOAD;
            OPC_JALR:   decoded.instr_class = JALR;
            OPC_STORE: begin
                decoded.instr_class = STORE;
                decoded.imm         = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            end
            OPC_BRANCH: begin
                decoded.instr_class = (funct3[2:1] == 2'b01) ? ILLEGAL : BRANCH;
                decoded.alu_op      = !funct3[2] ? ALU_EQ : (funct3[1] ? ALU_SLTU : ALU_SLT);
                decoded.imm         = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25],
                                       ir_q[11:8], 1'b0};
            end
            OPC_JAL: begin
                decoded.instr_class = JAL;
                decoded.imm         = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20],
                                       ir_q[30:21], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                decoded.instr_class = (opcode == OPC_LUI) ? LUI : AUIPC;
                decoded.imm         = {ir_q[31:12], 12'b0};
            end
            default: ;  // Stays ILLEGAL
        endcase
    end

    assign pc = pc_q;

endmodule

// ==== core_sequencer.sv ====
// Per-instruction state machine; all controls stay low in reset and in the first cycle after it
`timescale 1ns/10ps

module core_sequencer (
    input  logic                    clock,
    input  logic                    data_mem_rst,
    input  core_ctrl_pkg::decoded_t decoded,
    input  logic                    branch_taken,
    output core_ctrl_pkg::ctrl_t    ctrl
);
    import core_ctrl_pkg::*;

    seq_state_t   state_q;
    seq_state_t   state_d;
    logic         run_q;    // Low until the first edge after reset
    instr_class_t cls;

    assign cls = decoded.instr_class;

    always_ff @(posedge clock) begin
        if (data_mem_rst) begin
            state_q <= FETCH;
            run_q   <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (run_q) begin
                state_q <= state_d;
            end
        end
    end

    always_comb begin
        case (state_q)
            FETCH: state_d = DECODE;
            DECODE: begin
                case (cls)
                    JAL, LUI, AUIPC: state_d = WRITE_BACK;
                    ILLEGAL:         state_d = NEXT_PC;
                    default:         state_d = EXECUTE;
                endcase
            end
            EXECUTE: begin
                case (cls)
                    LOAD, STORE: state_d = MEMORY;
                    BRANCH:      state_d = NEXT_PC;
                    default:     state_d = WRITE_BACK;
                endcase
            end
            MEMORY:     state_d = (cls == LOAD) ? WRITE_BACK : NEXT_PC;
            WRITE_BACK: state_d = NEXT_PC;
            default:    state_d = FETCH;
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (run_q) begin
            case (state_q)
                FETCH: ctrl.ir_load = 1'b1;
                EXECUTE: begin
                    ctrl.result_load = 1'b1;
                    ctrl.use_imm     = cls inside {ALU_IMM, LOAD, STORE, JALR};
                end
                MEMORY: begin
                    ctrl.mem_we = (cls == STORE);
                    ctrl.mem_re = (cls == LOAD);
                end
                WRITE_BACK: begin
                    ctrl.rf_we = 1'b1;
                    case (cls)
                        LOAD:      ctrl.wb_sel = MEM;
                        JAL, JALR: ctrl.wb_sel = LINK;
                        LUI:       ctrl.wb_sel = IMM_U;
                        AUIPC:     ctrl.wb_sel = PC_IMM_U;
                        default:   ctrl.wb_sel = ALU;
                    endcase
                end
                NEXT_PC: begin
                    case (cls)
                        BRANCH:  ctrl.pc_sel = branch_taken ? OFFSET : STEP;
                        JAL:     ctrl.pc_sel = OFFSET;
                        JALR:    ctrl.pc_sel = REG_TARGET;
                        default: ctrl.pc_sel = STEP;  // ILLEGAL too
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== execute_unit.sv ====
// ALU, result and branch registers, 64-word data memory and write-back mux; word access only
`timescale 1ns/10ps

module execute_unit (
    input  logic                        clock,
    input  logic                        data_mem_rst,
    input  core_ctrl_pkg::decoded_t     decoded,
    input  core_ctrl_pkg::ctrl_t        ctrl,
    input  rv_isa_pkg::word_t           rs1_data,
    input  rv_isa_pkg::word_t           rs2_data,
    output logic                        branch_taken,
    output rv_isa_pkg::word_t           jump_target,
    output core_ctrl_pkg::wb_event_t    wb,
    output core_ctrl_pkg::store_event_t store
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t      alu_b;
    word_t      alu_result;
    word_t      result_q;    // Also the data memory byte address
    word_t      load_q;
    word_t      wb_data;
    logic       taken_q;
    mem_index_t dmem_idx;
    word_t      dmem [DMEM_DEPTH];

    assign alu_b = ctrl.use_imm ? decoded.imm : rs2_data;

    alu u_alu (
        .op     (decoded.alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result)
    );

    always_ff @(posedge clock) begin
        if (ctrl.result_load) begin
            result_q <= alu_result;
        end
    end

    always_ff @(posedge clock) begin
        if (data_mem_rst) begin
            taken_q <= 1'b0;
        end else if (ctrl.result_load && (decoded.instr_class == BRANCH)) begin
            taken_q <= alu_result[0] ^ decoded.funct3[0];  // BNE, BGE, BGEU invert
        end
    end

    assign dmem_idx = mem_index_t'(result_q >> 2);

    always_ff @(posedge clock) begin
        if (data_mem_rst) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrl.mem_we) begin
            dmem[dmem_idx] <= rs2_data;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.mem_re) begin
            load_q <= dmem[dmem_idx];
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            LINK:     wb_data = decoded.pc + word_t'(PC_STEP);
            IMM_U:    wb_data = decoded.imm;
            PC_IMM_U: wb_data = decoded.pc + decoded.imm;
            ALU:      wb_data = result_q;
            default:  wb_data = load_q;
        endcase
    end

    assign wb.valid    = ctrl.rf_we;
    assign wb.rd       = decoded.rd;
    assign wb.data     = wb_data;

    assign store.valid = ctrl.mem_we;
    assign store.addr  = result_q;
    assign store.data  = rs2_data;

    assign branch_taken = taken_q;
    assign jump_target  = {result_q[XLEN-1:1], 1'b0};  // JALR clears bit 0

endmodule

// ==== rv_core.sv ====
// Multi-cycle RV32I core top; load the instruction memory while data_mem_rst is high
`timescale 1ns/10ps

module rv_core (
    input  logic                        clock,
    input  logic                        data_mem_rst,
    input  logic                        imem_we,
    input  rv_isa_pkg::mem_index_t      imem_addr,
    input  rv_isa_pkg::word_t           imem_data,
    output rv_isa_pkg::word_t           pc,
    output core_ctrl_pkg::wb_event_t    retire,
    output core_ctrl_pkg::store_event_t store
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    decoded_t decoded;
    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    jump_target;
    logic     branch_taken;

    instr_fetch u_instr_fetch (
        .clock        (clock),
        .data_mem_rst (data_mem_rst),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .ctrl         (ctrl),
        .jump_target  (jump_target),
        .decoded      (decoded),
        .pc           (pc)
    );

    core_sequencer u_core_sequencer (
        .clock        (clock),
        .data_mem_rst (data_mem_rst),
        .decoded      (decoded),
        .branch_taken (branch_taken),
        .ctrl         (ctrl)
    );

    reg_file u_reg_file (
        .clock        (clock),
        .data_mem_rst (data_mem_rst),
        .rs1_addr     (decoded.rs1),
        .rs2_addr     (decoded.rs2),
        .write        (retire),      // Write-back event doubles as the retire output
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    execute_unit u_execute_unit (
        .clock        (clock),
        .data_mem_rst (data_mem_rst),
        .decoded      (decoded),
        .ctrl         (ctrl),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .branch_taken (branch_taken),
        .jump_target  (jump_target),
        .wb           (retire),
        .store        (store)
    );

endmodule

// ==== tb_rv_core.sv ====
// Reads rv_core_golden.txt from the run directory; each test ends on its halting JAL retire
`timescale 1ns/10ps

module tb_rv_core;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int EVENT_TIMEOUT = 100;  // Cycles allowed from one event to the next
    localparam int RESET_CYCLES  = 2;

    typedef struct packed {
        logic  is_store;
        word_t key;       // rd for a retire, byte address for a store
        word_t data;
    } exp_event_t;

    logic         clock;
    logic         data_mem_rst;
    logic         imem_we;
    mem_index_t   imem_addr;
    word_t        imem_data;
    word_t        pc;
    wb_event_t    retire;
    store_event_t store;

    word_t      program_words [$];
    exp_event_t expected [$];
    string      test_name;
    int         test_errors;
    int         tests_run;
    int         tests_bad;
    int         checks_run;
    int         checks_bad;
    bit         timed_out;

    rv_core u_rv_core (
        .clock        (clock),
        .data_mem_rst (data_mem_rst),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .pc           (pc),
        .retire       (retire),
        .store        (store)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;  // Drive and sample clear of the edge
    endtask

    function automatic string event_kind(input logic is_store);
        return is_store ? "store" : "retire";
    endfunction

    task automatic check(input bit ok, input string msg);
        checks_run++;
        assert (ok) else begin
            $display("[FAIL] %0t: %s: %s", $time, test_name, msg);
            checks_bad++;
            test_errors++;
        end
    endtask

    task automatic note_bad_record(input logic [7:0] rec);
        $display("Golden file has a malformed or unknown record starting with '%c'", rec);
        checks_bad++;
    endtask

    // Loader writes one word per cycle, then reset stays high for two more cycles
    task automatic hold_reset_and_load();
        data_mem_rst = 1'b1;
        foreach (program_words[i]) begin
            imem_we   = 1'b1;
            imem_addr = mem_index_t'(i);
            imem_data = program_words[i];
            next_cycle();
            check(pc == '0 && !retire.valid && !store.valid, "core not idle during reset");
        end
        imem_we = 1'b0;
        repeat (RESET_CYCLES) begin
            next_cycle();
            check(pc == '0 && !retire.valid && !store.valid, "core not idle during reset");
        end
        data_mem_rst = 1'b0;
    endtask

    task automatic wait_for_event(output exp_event_t got, output bit timeout);
        int cycles;
        timeout = 1'b1;
        got     = '0;
        for (cycles = 0; cycles < EVENT_TIMEOUT; cycles++) begin
            next_cycle();
            if (retire.valid || store.valid) begin
                got.is_store = store.valid;
                got.key      = store.valid ? store.addr : word_t'(retire.rd);
                got.data     = store.valid ? store.data : retire.data;
                timeout      = 1'b0;
                break;
            end
        end
    endtask

    task automatic run_test();
        exp_event_t got;
        exp_event_t want;
        test_errors = 0;
        hold_reset_and_load();
        foreach (expected[n]) begin
            want = expected[n];
            wait_for_event(got, timed_out);
            if (timed_out) begin
                $display("Timeout in test %s: expected %s event %0d never arrived",
                         test_name, event_kind(want.is_store), n);
                return;
            end
            check(got == want, $sformatf("event %0d got %s %h %h, expected %s %h %h", n,
                  event_kind(got.is_store), got.key, got.data,
                  event_kind(want.is_store), want.key, want.data));
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_bad++;
        end
        $display("Test %s done with %0d mismatches", test_name, test_errors);
        program_words.delete();
        expected.delete();
    endtask

    initial begin
        int               fd;
        int               code;
        logic [8*32-1:0]  tok;
        logic [8*256-1:0] rest;
        logic [7:0]       rec;
        word_t            a;
        word_t            b;
        data_mem_rst = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        tests_run    = 0;
        tests_bad    = 0;
        checks_run   = 0;
        checks_bad   = 0;
        timed_out    = 1'b0;
        test_name    = "reset";
        run_test();  // Empty program, reset behavior only

        fd = $fopen("rv_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open rv_core_golden.txt, no program to run");
            checks_bad++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", tok) == 1) begin
                rec = (tok[8*32-1:8] == '0) ? tok[7:0] : 8'h3f;  // Only single-letter records
                case (rec)
                    "#": code = $fgets(rest, fd);
                    "T": begin
                        code      = $fscanf(fd, "%s", tok);
                        test_name = $sformatf("%0s", tok);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h", a);
                        if (code != 1) note_bad_record(rec);
                        else program_words.push_back(a);
                    end
                    "R", "S": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        if (code != 2) note_bad_record(rec);
                        else expected.push_back(exp_event_t'{is_store: (rec == "S"),
                                                             key: a, data: b});
                    end
                    "E": run_test();
                    default: note_bad_record(rec);
                endcase
            end
            $fclose(fd);
        end

        $display("Summary: %0d tests, %0d with mismatches, %0d checks run, %0d mismatched",
                 tests_run, tests_bad, checks_run, checks_bad);
        if (checks_bad == 0 && !timed_out && tests_run > 1) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== rv_core_golden.txt ====
# T name starts a test, P hex is the next program word from address 0, E runs the test
# R rd data is an expected retire, S byte_addr data an expected store, both in event order
T alu
P FF800093  R 01 FFFFFFF8  # addi x1, x0, -8
P 00300113  R 02 00000003  # addi x2, x0, 3
P 002081B3  R 03 FFFFFFFB  # add  x3, x1, x2
P 40110233  R 04 0000000B  # sub  x4, x2, x1
P 4020D2B3  R 05 FFFFFFFF  # sra  x5, x1, x2
P 0020D333  R 06 1FFFFFFF  # srl  x6, x1, x2
P 0020A3B3  R 07 00000001  # slt  x7, x1, x2
P 0020B433  R 08 00000000  # sltu x8, x1, x2
P 0F00C493  R 09 FFFFFF08  # xori x9, x1, 0xf0
P 10016513  R 0A 00000103  # ori  x10, x2, 0x100
P 07F0F593  R 0B 00000078  # andi x11, x1, 0x7f
P 00411613  R 0C 00000030  # slli x12, x2, 4
P 4010D693  R 0D FFFFFFFC  # srai x13, x1, 1
P FFF12713  R 0E 00000000  # slti x14, x2, -1
P FFF13793  R 0F 00000001  # sltiu x15, x2, -1
P 0000006F  R 00 00000040  # jal x0, 0 halts at 0x3c
E
T mem
P 12345137  R 02 12345000  # lui  x2, 0x12345
P 67810113  R 02 12345678  # addi x2, x2, 0x678
P 04000093  R 01 00000040  # addi x1, x0, 0x40
P 0020A223  S 00000044 12345678  # sw x2, 4(x1)
P FE10AE23  S 0000003C 00000040  # sw x1, -4(x1)
P 0040A183  R 03 12345678  # lw x3, 4(x1)
P FFC0A203  R 04 00000040  # lw x4, -4(x1)
P 0080A283  R 05 00000000  # lw x5, 8(x1) was cleared by reset
P 0000006F  R 00 00000024  # jal x0, 0 halts at 0x20
E
T branch
P FFF00093  R 01 FFFFFFFF  # addi x1, x0, -1
P 00100113  R 02 00000001  # addi x2, x0, 1
P 00108463  P 00100513  # beq  x1, x1 taken, marker 1 skipped
P 00208463  P 00200513  R 0A 00000002  # beq  x1, x2 not taken
P 00209463  P 00300513  # bne  x1, x2 taken
P 00109463  P 00400513  R 0A 00000004  # bne  x1, x1 not taken
P 0020C463  P 00500513  # blt  x1, x2 taken
P 00114463  P 00600513  R 0A 00000006  # blt  x2, x1 not taken
P 00115463  P 00700513  # bge  x2, x1 taken
P 0020D463  P 00800513  R 0A 00000008  # bge  x1, x2 not taken
P 00116463  P 00900513  # bltu x2, x1 taken
P 0020E463  P 00A00513  R 0A 0000000A  # bltu x1, x2 not taken
P 0020F463  P 00B00513  # bgeu x1, x2 taken
P 00117463  P 00C00513  R 0A 0000000C  # bgeu x2, x1 not taken
P 0000006F  R 00 0000006C  # jal x0, 0 halts at 0x68
E
T jump
P 00C000EF  R 01 00000004  # jal x1, 12 to 0x0c
P 00100513  # skipped
P 00200513  # skipped
P 00001297  R 05 0000100C  # auipc x5, 0x1 at 0x0c
P FFFFF337  R 06 FFFFF000  # lui x6, 0xfffff
P 01D003E7  R 07 00000018  # jalr x7, 0x1d(x0) lands on 0x1c
P 00300513  # skipped
P 00500013  R 00 00000005  # addi x0, x0, 5 retires but is dropped
P 00700413  R 08 00000007  # addi x8, x0, 7 reads x0 as zero
P 02D084E7  R 09 00000028  # jalr x9, 0x2d(x1) lands on 0x30
P 00400513  # skipped
P 00500513  # skipped
P 0000006F  R 00 00000034  # jal x0, 0 halts at 0x30
E

// ==== rv_core.f ====
rv_isa_pkg.sv
core_ctrl_pkg.sv
alu.sv
reg_file.sv
instr_fetch.sv
core_sequencer.sv
execute_unit.sv
rv_core.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_rv_core
RTL_TOP    = rv_core
FILELIST   = rv_core.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Checks failed

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
